/* include/addr_map_consts.svh */
/* Global sizes of the peripheral interconnect slice
   Included by the package, the RTL and the testbench */

`ifndef ADDR_MAP_CONSTS_SVH
`define ADDR_MAP_CONSTS_SVH

// Width of a bus address and of every rule boundary
`define ADDR_W 32

// Width of a data word on the bus and in the memories
`define DATA_W 32

// Number of range rules in the address map
`define N_RULES 4

// Number of scratch memories behind the demux
`define N_TARGETS 4

// Words per scratch memory, selected by address bits 5 down to 2
`define MEM_WORDS 16

`endif

/* hw/addr_map_pkg.sv */
/* Shared types of the address map, the request path and the configuration port
   Referenced by scoped names from every module of the slice */

`default_nettype none

package addr_map_pkg;

  `include "addr_map_consts.svh"

  // Plain address word
  typedef logic [`ADDR_W-1:0] addr_t;

  // Target index, wide enough for every memory
  typedef logic [$clog2(`N_TARGETS)-1:0] idx_t;

  // One range rule, start inclusive and end exclusive
  // An end of zero stands for the top of the address space
  typedef struct packed {
    idx_t  idx;
    addr_t start_addr;
    addr_t end_addr;
  } rule_t;

  // Single-cycle request strobe from the master
  typedef struct packed {
    logic               valid;
    logic               we;
    addr_t              addr;
    logic [`DATA_W-1:0] wdata;
  } bus_req_t;

  // Response pulse, one per request
  typedef struct packed {
    logic               valid;
    logic               err;
    logic [`DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Configuration operations on the staged map
  typedef enum logic [2:0] {
    CFG_START   = 3'd0,
    CFG_END     = 3'd1,
    CFG_IDX     = 3'd2,
    CFG_DEFAULT = 3'd3,
    CFG_COMMIT  = 3'd4
  } cfg_op_e;

  // Configuration strobe, rule_sel picks the staged rule
  typedef struct packed {
    logic                         valid;
    cfg_op_e                      op;
    logic [$clog2(`N_RULES)-1:0]  rule_sel;
    logic [31:0]                  wdata;
  } cfg_req_t;

endpackage

`default_nettype wire

/* hw/scratch_mem.sv */
/* One scratch target, a small word-addressed memory
   Writes on the sampling edge and returns registered read data one cycle later */

`timescale 1ns/1ps
`default_nettype none

`include "addr_map_consts.svh"

module scratch_mem (
  input  logic                   clk_i,
  input  addr_map_pkg::bus_req_t tgt_req_i,
  output logic [`DATA_W-1:0]     rdata_o
);

  // Word select width, bits above it are ignored
  localparam int unsigned WordAw = $clog2(`MEM_WORDS);

  logic [`DATA_W-1:0] mem_q [`MEM_WORDS];
  logic [WordAw-1:0]  word_sel;

  // Byte offset bits 1:0 are dropped, the word sits right above them
  assign word_sel = tgt_req_i.addr[WordAw+1:2];

  always_ff @(posedge clk_i) begin
    if (tgt_req_i.valid && tgt_req_i.we) begin
      mem_q[word_sel] <= tgt_req_i.wdata;
    end
  end

  // Read on every access, a write returns the word it overwrote
  always_ff @(posedge clk_i) begin
    if (tgt_req_i.valid) begin
      rdata_o <= mem_q[word_sel];
    end
  end

endmodule

`default_nettype wire

/* hw/addr_decode_dync.sv */
/* Combinational address decoder over a run-time address map
   Highest matching rule wins, with optional default target and blanking during configuration */

`timescale 1ns/1ps
`default_nettype none

`include "addr_map_consts.svh"

module addr_decode_dync #(
  // Number of rules scanned in the map
  parameter int unsigned NoRules = `N_RULES,
  // Rules hold base and mask instead of start and end when set
  parameter bit          Napot   = 1'b0
) (
  input  addr_map_pkg::addr_t               addr_i,
  input  addr_map_pkg::rule_t [NoRules-1:0] addr_map_i,
  input  logic                              en_default_idx_i,
  input  addr_map_pkg::idx_t                default_idx_i,
  input  logic                              config_ongoing_i,
  output addr_map_pkg::idx_t                idx_o,
  output logic                              dec_valid_o,
  output logic                              dec_error_o
);

  // Any rule matched the address
  logic               hit;
  // Index of the last matching rule in scan order
  addr_map_pkg::idx_t hit_idx;

  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    // Scanning upwards lets a later rule overwrite an earlier one
    for (int unsigned i = 0; i < NoRules; i++) begin
      if (Napot) begin
        // Bits under the mask must equal the base
        if ((addr_i & addr_map_i[i].end_addr) ==
            (addr_map_i[i].start_addr & addr_map_i[i].end_addr)) begin
          hit     = 1'b1;
          hit_idx = addr_map_i[i].idx;
        end
      end else begin
        // Range rule, an end of zero runs to the top of the space
        if ((addr_i >= addr_map_i[i].start_addr) &&
            ((addr_i < addr_map_i[i].end_addr) || (addr_map_i[i].end_addr == '0))) begin
          hit     = 1'b1;
          hit_idx = addr_map_i[i].idx;
        end
      end
    end
  end

  always_comb begin
    if (config_ongoing_i) begin
      // Half-written map, report neither a decode nor a match
      idx_o       = '0;
      dec_valid_o = 1'b0;
      dec_error_o = 1'b1;
    end else if (hit) begin
      idx_o       = hit_idx;
      dec_valid_o = 1'b1;
      dec_error_o = 1'b0;
    end else if (en_default_idx_i) begin
      // Unmapped address falls through to the default target
      idx_o       = default_idx_i;
      dec_valid_o = 1'b1;
      dec_error_o = 1'b0;
    end else begin
      idx_o       = '0;
      dec_valid_o = 1'b0;
      dec_error_o = 1'b1;
    end
  end

  // Inputs may still be undriven before reset, so unknown flags are skipped
  a_dec_sane: assert final ($isunknown({dec_valid_o, dec_error_o}) ||
                            (!(dec_valid_o && dec_error_o) &&
                             (!dec_valid_o || (int'(idx_o) < `N_TARGETS))))
    else $error("decoder flags or index inconsistent");

endmodule

`default_nettype wire

/* hw/addr_map_regs.sv */
/* Staging and active copies of the address map behind the configuration port
   Staged writes go live on a commit strobe and flag configuration as ongoing meanwhile */

`timescale 1ns/1ps
`default_nettype none

`include "addr_map_consts.svh"

module addr_map_regs (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  addr_map_pkg::cfg_req_t                cfg_req_i,
  output addr_map_pkg::rule_t [`N_RULES-1:0]    addr_map_o,
  output logic                                  en_default_o,
  output addr_map_pkg::idx_t                    default_idx_o,
  output logic                                  cfg_ongoing_o
);

  // Map being edited by software
  addr_map_pkg::rule_t [`N_RULES-1:0] stg_map_q;
  logic                               stg_en_default_q;
  addr_map_pkg::idx_t                 stg_default_idx_q;

  // Map seen by the decoder
  addr_map_pkg::rule_t [`N_RULES-1:0] act_map_q;
  logic                               act_en_default_q;
  addr_map_pkg::idx_t                 act_default_idx_q;

  // Set by the first staged write, cleared by the commit
  logic ongoing_q;

  // Decoded strobes of the configuration port
  logic cfg_stage;
  logic cfg_commit;

  assign cfg_commit = cfg_req_i.valid && (cfg_req_i.op == addr_map_pkg::CFG_COMMIT);
  assign cfg_stage  = cfg_req_i.valid &&
                      (cfg_req_i.op inside {addr_map_pkg::CFG_START, addr_map_pkg::CFG_END,
                                            addr_map_pkg::CFG_IDX, addr_map_pkg::CFG_DEFAULT});

  // Field writes into the staged copy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stg_map_q         <= '0;
      stg_en_default_q  <= 1'b0;
      stg_default_idx_q <= '0;
    end else if (cfg_req_i.valid) begin
      case (cfg_req_i.op)
        addr_map_pkg::CFG_START: begin
          stg_map_q[cfg_req_i.rule_sel].start_addr <= cfg_req_i.wdata;
        end
        addr_map_pkg::CFG_END: begin
          stg_map_q[cfg_req_i.rule_sel].end_addr <= cfg_req_i.wdata;
        end
        addr_map_pkg::CFG_IDX: begin
          stg_map_q[cfg_req_i.rule_sel].idx <= addr_map_pkg::idx_t'(cfg_req_i.wdata);
        end
        addr_map_pkg::CFG_DEFAULT: begin
          // Bit 8 enables the default target, the low bits select it
          stg_en_default_q  <= cfg_req_i.wdata[8];
          stg_default_idx_q <= addr_map_pkg::idx_t'(cfg_req_i.wdata);
        end
        default: begin
          // Commit and unused codes leave the staged copy alone
        end
      endcase
    end
  end

  // Whole staged map goes live at once
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      act_map_q         <= '0;
      act_en_default_q  <= 1'b0;
      act_default_idx_q <= '0;
    end else if (cfg_commit) begin
      act_map_q         <= stg_map_q;
      act_en_default_q  <= stg_en_default_q;
      act_default_idx_q <= stg_default_idx_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ongoing_q <= 1'b0;
    end else if (cfg_commit) begin
      ongoing_q <= 1'b0;
    end else if (cfg_stage) begin
      ongoing_q <= 1'b1;
    end
  end

  assign addr_map_o    = act_map_q;
  assign en_default_o  = act_en_default_q;
  assign default_idx_o = act_default_idx_q;
  assign cfg_ongoing_o = ongoing_q;

  // Each committed range must be non-empty unless it runs to the top
  for (genvar i = 0; i < `N_RULES; i++) begin : g_rule_chk
    a_rule_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cfg_commit |=> ((act_map_q[i].end_addr == '0) ||
                      (act_map_q[i].start_addr < act_map_q[i].end_addr)))
      else $error("committed rule %0d has start at or above end", i);
  end

endmodule

`default_nettype wire

/* hw/req_demux.sv */
/* Routes master requests to the decoded memory and returns one response per request
   Failed decodes are answered with an error pulse one clock after the request */

`timescale 1ns/1ps
`default_nettype none

`include "addr_map_consts.svh"

module req_demux (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  addr_map_pkg::bus_req_t                     bus_req_i,
  output addr_map_pkg::addr_t                        dec_addr_o,
  input  addr_map_pkg::idx_t                         dec_idx_i,
  input  logic                                       dec_valid_i,
  output addr_map_pkg::bus_req_t [`N_TARGETS-1:0]    tgt_req_o,
  input  logic [`N_TARGETS-1:0][`DATA_W-1:0]         tgt_rdata_i,
  output addr_map_pkg::bus_rsp_t                     bus_rsp_o
);

  // Per-target strobes, gathered for the one-hot check
  logic [`N_TARGETS-1:0] tgt_valid;

  // Response state of the request sampled on the last edge
  logic               rsp_valid_q;
  logic               rsp_err_q;
  addr_map_pkg::idx_t rsp_idx_q;

  // Decoder sees the live address in the same cycle
  assign dec_addr_o = bus_req_i.addr;

  always_comb begin
    for (int unsigned t = 0; t < `N_TARGETS; t++) begin
      // All targets share address and data, only the strobe is steered
      tgt_valid[t]       = bus_req_i.valid && dec_valid_i &&
                           (dec_idx_i == addr_map_pkg::idx_t'(t));
      tgt_req_o[t]       = bus_req_i;
      tgt_req_o[t].valid = tgt_valid[t];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= bus_req_i.valid;
      // An invalid decode covers both unmapped and mid-configuration cases
      rsp_err_q   <= bus_req_i.valid && !dec_valid_i;
    end
  end

  // Target of the pending response, used only to pick read data
  always_ff @(posedge clk_i) begin
    if (bus_req_i.valid) begin
      rsp_idx_q <= dec_idx_i;
    end
  end

  always_comb begin
    bus_rsp_o.valid = rsp_valid_q;
    bus_rsp_o.err   = rsp_err_q;
    // Error responses carry zero instead of stale memory data
    bus_rsp_o.rdata = (rsp_valid_q && !rsp_err_q) ? tgt_rdata_i[rsp_idx_q] : '0;
  end

  // Never more than one memory addressed per cycle
  a_tgt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(tgt_valid))
    else $error("more than one target selected");

endmodule

`default_nettype wire

/* hw/periph_bus_top.sv */
/* Top of the peripheral interconnect slice
   Joins the map registers, decoder, demux and four scratch memories */

`timescale 1ns/1ps
`default_nettype none

`include "addr_map_consts.svh"

module periph_bus_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  addr_map_pkg::bus_req_t bus_req_i,
  input  addr_map_pkg::cfg_req_t cfg_req_i,
  output addr_map_pkg::bus_rsp_t bus_rsp_o,
  output logic                   cfg_ongoing_o
);

  // Live map from the registers to the decoder
  addr_map_pkg::rule_t [`N_RULES-1:0]      addr_map;
  logic                                    en_default;
  addr_map_pkg::idx_t                      default_idx;

  // Decoder handshake with the demux
  addr_map_pkg::addr_t                     dec_addr;
  addr_map_pkg::idx_t                      dec_idx;
  logic                                    dec_valid;

  // Target side of the demux
  addr_map_pkg::bus_req_t [`N_TARGETS-1:0] tgt_req;
  logic [`N_TARGETS-1:0][`DATA_W-1:0]      tgt_rdata;

  addr_map_regs addr_map_regs_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cfg_req_i     (cfg_req_i),
    .addr_map_o    (addr_map),
    .en_default_o  (en_default),
    .default_idx_o (default_idx),
    .cfg_ongoing_o (cfg_ongoing_o)
  );

  // Error status reaches the master through bus_rsp_o.err, so dec_error stays open
  addr_decode_dync #(
    .NoRules (`N_RULES),
    .Napot   (1'b0)
  ) addr_decode_dync_inst (
    .addr_i           (dec_addr),
    .addr_map_i       (addr_map),
    .en_default_idx_i (en_default),
    .default_idx_i    (default_idx),
    .config_ongoing_i (cfg_ongoing_o),
    .idx_o            (dec_idx),
    .dec_valid_o      (dec_valid),
    .dec_error_o      ()
  );

  req_demux req_demux_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .bus_req_i   (bus_req_i),
    .dec_addr_o  (dec_addr),
    .dec_idx_i   (dec_idx),
    .dec_valid_i (dec_valid),
    .tgt_req_o   (tgt_req),
    .tgt_rdata_i (tgt_rdata),
    .bus_rsp_o   (bus_rsp_o)
  );

  for (genvar t = 0; t < `N_TARGETS; t++) begin : g_mem
    scratch_mem scratch_mem_inst (
      .clk_i     (clk_i),
      .tgt_req_i (tgt_req[t]),
      .rdata_o   (tgt_rdata[t])
    );
  end

endmodule

`default_nettype wire

/* test/tb_periph_bus.sv */
/* Table-driven testbench for the peripheral interconnect slice
   A reference model of the address map and memories predicts every response */

`timescale 1ns/1ps
`default_nettype none

`include "addr_map_consts.svh"

module tb_periph_bus;

  typedef enum {K_IDLE, K_CFG, K_COMMIT, K_REQ} kind_e;

  // One table step, applied in one clock cycle
  typedef struct {
    int                    test;
    kind_e                 kind;
    addr_map_pkg::cfg_op_e op;
    logic [1:0]            sel;
    logic [31:0]           data;
    logic                  we;
    logic [31:0]           addr;
    // Low means exp_err and exp_rdata are taken from the table
    logic                  compute;
    logic                  exp_err;
    logic [31:0]           exp_rdata;
  } step_t;

  // What the DUT must show for a step
  typedef struct packed {
    logic        is_req;
    logic        err;
    logic        chk_rdata;
    logic [31:0] rdata;
    logic        ongoing;
  } expect_t;

  logic                   clk;
  logic                   arst_n;
  addr_map_pkg::bus_req_t bus_req;
  addr_map_pkg::cfg_req_t cfg_req;
  addr_map_pkg::bus_rsp_t bus_rsp;
  logic                   cfg_ongoing;

  step_t   tbl[$];
  expect_t results[$];
  logic    tbl_ready = 1'b0;
  int      err_total = 0;
  int      check_total = 0;
  int      test_errs [1:6];

  // Reference copies of the map and of the four memories
  addr_map_pkg::rule_t ref_stg [`N_RULES];
  addr_map_pkg::rule_t ref_act [`N_RULES];
  logic                stg_def_en;
  logic                act_def_en;
  logic                ref_ongoing;
  logic [1:0]          stg_def_idx;
  logic [1:0]          act_def_idx;
  logic [31:0]         ref_mem [`N_TARGETS][`MEM_WORDS];

  periph_bus_top periph_bus_top_inst (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .bus_req_i     (bus_req),
    .cfg_req_i     (cfg_req),
    .bus_rsp_o     (bus_rsp),
    .cfg_ongoing_o (cfg_ongoing)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic string test_name(input int t);
    case (t)
      1: return "reset map sends all to target 0";
      2: return "four disjoint ranges";
      3: return "overlapping rules, higher rule wins";
      4: return "default mapping on and off";
      5: return "requests rejected while configuring";
      default: return "back-to-back requests";
    endcase
  endfunction

  // Highest-numbered matching rule first, then the default, else an error
  function automatic logic decode_ref(input logic [31:0] a, output logic [1:0] idx);
    idx = '0;
    if (ref_ongoing) return 1'b0;
    for (int i = `N_RULES - 1; i >= 0; i--) begin
      if (a >= ref_act[i].start_addr &&
          (ref_act[i].end_addr == '0 || a < ref_act[i].end_addr)) begin
        idx = ref_act[i].idx;
        return 1'b1;
      end
    end
    idx = act_def_idx;
    return act_def_en;
  endfunction

  task automatic add_step(input int t, input kind_e k, input addr_map_pkg::cfg_op_e op,
                          input logic [1:0] sel, input logic [31:0] d, input logic we,
                          input logic [31:0] a, input logic comp, input logic e_err);
    step_t s;
    s = '{t, k, op, sel, d, we, a, comp, e_err, 32'h0};
    tbl.push_back(s);
  endtask

  task automatic add_cfg(input int t, input addr_map_pkg::cfg_op_e op, input int sel,
                         input logic [31:0] d);
    add_step(t, K_CFG, op, sel[1:0], d, 1'b0, 32'h0, 1'b1, 1'b0);
  endtask

  task automatic add_commit(input int t);
    add_step(t, K_COMMIT, addr_map_pkg::CFG_COMMIT, 2'd0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0);
  endtask

  task automatic add_req(input int t, input logic we, input logic [31:0] a);
    add_step(t, K_REQ, addr_map_pkg::CFG_START, 2'd0, 32'h0, we, a, 1'b1, 1'b0);
  endtask

  // Read with a fixed expected error from the table
  task automatic add_fixed_read(input int t, input logic [31:0] a, input logic e_err);
    add_step(t, K_REQ, addr_map_pkg::CFG_START, 2'd0, 32'h0, 1'b0, a, 1'b0, e_err);
  endtask

  task automatic add_idle(input int t);
    add_step(t, K_IDLE, addr_map_pkg::CFG_START, 2'd0, 32'h0, 1'b0, 32'h0, 1'b1, 1'b0);
  endtask

  task automatic build_table();
    add_req(1, 1'b1, 32'h0000_0004);
    add_req(1, 1'b1, 32'h8000_0008);
    add_req(1, 1'b0, 32'h0000_0004);
    add_req(1, 1'b0, 32'h0000_0008);
    // Rule i covers 4 KiB starting at (i+1) * 4 KiB and maps to target i
    for (int i = 0; i < 4; i++) begin
      add_cfg(2, addr_map_pkg::CFG_START, i, (i + 1) << 12);
      add_cfg(2, addr_map_pkg::CFG_END, i, (i + 2) << 12);
      add_cfg(2, addr_map_pkg::CFG_IDX, i, i);
    end
    add_commit(2);
    for (int i = 0; i < 4; i++) add_req(2, 1'b1, ((i + 1) << 12) | 32'h10);
    for (int i = 0; i < 4; i++) add_req(2, 1'b0, ((i + 1) << 12) | 32'h10);
    add_fixed_read(2, 32'h0000_0004, 1'b1);
    // Rule 3 moves over the boundary of rules 0 and 1
    add_cfg(3, addr_map_pkg::CFG_START, 3, 32'h1800);
    add_cfg(3, addr_map_pkg::CFG_END, 3, 32'h2800);
    add_commit(3);
    add_req(3, 1'b1, 32'h1808);
    add_req(3, 1'b0, 32'h1808);
    add_req(3, 1'b0, 32'h1008);
    add_req(3, 1'b0, 32'h2008);
    add_req(3, 1'b0, 32'h4010);
    add_cfg(4, addr_map_pkg::CFG_DEFAULT, 0, 32'h102);
    add_commit(4);
    add_req(4, 1'b0, 32'h4010);
    add_req(4, 1'b1, 32'h9000_0014);
    add_req(4, 1'b0, 32'h3014);
    add_cfg(4, addr_map_pkg::CFG_DEFAULT, 0, 32'h002);
    add_commit(4);
    add_req(4, 1'b0, 32'h9000_0014);
    add_cfg(5, addr_map_pkg::CFG_START, 0, 32'h6000);
    add_req(5, 1'b0, 32'h1010);
    add_req(5, 1'b1, 32'h2010);
    add_cfg(5, addr_map_pkg::CFG_END, 0, 32'h7000);
    add_req(5, 1'b0, 32'h2010);
    add_commit(5);
    add_req(5, 1'b0, 32'h2010);
    add_req(5, 1'b0, 32'h6010);
    add_req(5, 1'b0, 32'h1010);
    add_idle(6);
    add_req(6, 1'b1, 32'h2020);
    add_req(6, 1'b1, 32'h3020);
    add_req(6, 1'b0, 32'h2020);
    add_req(6, 1'b0, 32'h3020);
    add_fixed_read(6, 32'h0000_0008, 1'b1);
    add_req(6, 1'b0, 32'h2020);
    add_idle(6);
  endtask

  // Drives one step and advances the model to the state after its sampling edge
  task automatic apply_step(input step_t s, output expect_t e);
    logic [1:0]  idx;
    logic        ok;
    logic [31:0] wd;
    bus_req = '0;
    cfg_req = '0;
    e = '0;
    case (s.kind)
      K_CFG: begin
        cfg_req.valid    = 1'b1;
        cfg_req.op       = s.op;
        cfg_req.rule_sel = s.sel;
        cfg_req.wdata    = s.data;
        case (s.op)
          addr_map_pkg::CFG_START: ref_stg[s.sel].start_addr = s.data;
          addr_map_pkg::CFG_END:   ref_stg[s.sel].end_addr = s.data;
          addr_map_pkg::CFG_IDX:   ref_stg[s.sel].idx = s.data[1:0];
          default: begin
            stg_def_en  = s.data[8];
            stg_def_idx = s.data[1:0];
          end
        endcase
        ref_ongoing = 1'b1;
      end
      K_COMMIT: begin
        cfg_req.valid = 1'b1;
        cfg_req.op    = addr_map_pkg::CFG_COMMIT;
        ref_act       = ref_stg;
        act_def_en    = stg_def_en;
        act_def_idx   = stg_def_idx;
        ref_ongoing   = 1'b0;
      end
      K_REQ: begin
        wd            = $urandom;
        bus_req.valid = 1'b1;
        bus_req.we    = s.we;
        bus_req.addr  = s.addr;
        bus_req.wdata = wd;
        ok            = decode_ref(s.addr, idx);
        if (ok && s.we) ref_mem[idx][s.addr[5:2]] = wd;
        e.is_req    = 1'b1;
        e.err       = s.compute ? !ok : s.exp_err;
        e.chk_rdata = !s.we && !e.err;
        e.rdata     = s.compute ? ref_mem[idx][s.addr[5:2]] : s.exp_rdata;
      end
      default: begin
      end
    endcase
    e.ongoing = ref_ongoing;
  endtask

  task automatic check_value(input int t, input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_total++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: test %0d %s is %h, expected %h",
               $time, t, what, got, exp);
      err_total++;
      test_errs[t]++;
    end
  endtask

  // Checks the response of step j and closes its test after the last step
  task automatic check_response(input int j);
    int t;
    t = tbl[j].test;
    check_value(t, $sformatf("step %0d rsp valid", j), bus_rsp.valid, results[j].is_req);
    if (results[j].is_req) check_value(t, $sformatf("step %0d err", j), bus_rsp.err,
                                       results[j].err);
    if (results[j].chk_rdata) check_value(t, $sformatf("step %0d rdata", j), bus_rsp.rdata,
                                          results[j].rdata);
    if (j == tbl.size() - 1 || tbl[j + 1].test != t) begin
      $display("test %0d %s: %s (%0d errors)", t, test_name(t),
               (test_errs[t] == 0) ? "ok" : "bad", test_errs[t]);
    end
  endtask

  initial begin
    expect_t e;
    int      n;
    void'($urandom(32'h71ec));
    bus_req = '0;
    cfg_req = '0;
    arst_n  = 1'b0;
    foreach (test_errs[t]) test_errs[t] = 0;
    foreach (ref_stg[i]) ref_stg[i] = '0;
    ref_act     = ref_stg;
    stg_def_en  = 1'b0;
    act_def_en  = 1'b0;
    stg_def_idx = '0;
    act_def_idx = '0;
    ref_ongoing = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (3) @(posedge clk);
    #2 arst_n = 1'b1;
    n = tbl.size();
    // Flags and response of step k both show right after the edge that samples it
    for (int k = 0; k < n + 1; k++) begin
      @(posedge clk);
      #2;
      if (k >= 1) begin
        check_value(tbl[k - 1].test, $sformatf("step %0d cfg_ongoing", k - 1),
                    cfg_ongoing, results[k - 1].ongoing);
        check_response(k - 1);
      end
      if (k < n) begin
        apply_step(tbl[k], e);
        results.push_back(e);
      end else begin
        bus_req = '0;
        cfg_req = '0;
      end
    end
    $display("Summary: 6 tests, %0d checks, %0d errors", check_total, err_total);
    if (err_total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // The table needs one cycle per step plus reset and pipeline slack
  initial begin
    wait (tbl_ready);
    #((tbl.size() + 20) * 20);
    $display("Timeout: the step table did not complete in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hw/addr_map_pkg.sv
hw/scratch_mem.sv
hw/addr_decode_dync.sv
hw/addr_map_regs.sv
hw/req_demux.sv
hw/periph_bus_top.sv
test/tb_periph_bus.sv

/* Bender.yml */
package:
  name: periph_bus

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/addr_map_pkg.sv
      - hw/scratch_mem.sv
      - hw/addr_decode_dync.sv
      - hw/addr_map_regs.sv
      - hw/req_demux.sv
      - hw/periph_bus_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_periph_bus.sv
